// ==== bench/boot_top_tb.sv ====
`timescale 1ns/10ps

module boot_top_tb import boot_pkg::*; ();

	localparam int BOOT_WORDS = 64;
	localparam int FLASH_WAIT = 4;
	localparam int RAM_WAIT = 2;
	localparam int WORD_CYCLES = FLASH_WAIT + RAM_WAIT + 4;
	localparam int RUN_CYCLES = 4 * BOOT_WORDS * WORD_CYCLES;
	// Two copy runs plus reset and idle time
	localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 200;

	logic clk = 1'b0;
	logic arst_n;
	logic start;
	flash_addr_t flash_addr;
	logic flash_ce_n;
	logic flash_oe_n;
	word_t flash_data;
	ram_addr_t ram_addr;
	word_t ram_data;
	logic ram_en_n;
	logic ram_we_n;
	seg_t seg_hi;
	seg_t seg_lo;
	word_t checksum;
	logic boot_done;

	integer seed = 32'h5123_cd15;
	word_t flash_mem [0:BOOT_WORDS-1];
	word_t sram_mem [0:BOOT_WORDS-1];
	int write_cnt = 0;
	int stray_writes = 0;
	int unselected_writes = 0;
	int overlap_cnt = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_start_errors;
	int run_cycles;
	logic done_fell;

	always #10 clk = ~clk;

	boot_top #(
		.BOOT_WORDS(BOOT_WORDS),
		.FLASH_WAIT(FLASH_WAIT),
		.RAM_WAIT(RAM_WAIT)
	) UUT (
		.raw_clk(clk),
		.arst_n(arst_n),
		.start(start),
		.flash_addr(flash_addr),
		.flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n),
		.flash_data(flash_data),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.ram_en_n(ram_en_n),
		.ram_we_n(ram_we_n),
		.seg_hi(seg_hi),
		.seg_lo(seg_lo),
		.checksum(checksum),
		.boot_done(boot_done)
	);

	// Flash answers only while both strobes are low and the address is in range
	assign flash_data = (!flash_ce_n && !flash_oe_n && flash_addr < BOOT_WORDS) ?
		flash_mem[flash_addr[5:0]] : 'x;

	// SRAM model takes the word at the end of the write strobe
	always @(posedge ram_we_n) begin
		if (arst_n === 1'b1) begin
			if (ram_addr < BOOT_WORDS)
				sram_mem[ram_addr] = ram_data;
			else
				stray_writes++;
			write_cnt++;
		end
	end

	// Flash and SRAM must never be selected in the same cycle
	always @(negedge clk) begin
		if (arst_n === 1'b1 && !flash_ce_n && !ram_en_n)
			overlap_cnt++;
	end

	// A write strobe needs the SRAM enabled
	always @(negedge clk) begin
		if (arst_n === 1'b1 && !ram_we_n && ram_en_n)
			unselected_writes++;
	end

	initial begin
		#(WATCHDOG_CYCLES * 20);
		$display("timeout: the copy did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic word_t ref_checksum();
		word_t sum;
		sum = '0;
		for (int i = 0; i < BOOT_WORDS; i++)
			sum = sum + flash_mem[i];
		return sum;
	endfunction

	// Lit segments per hex digit, then turned into an active low pattern
	function automatic seg_t ref_seg(input logic [3:0] nib);
		string lit;
		seg_t pat;
		case (nib)
			4'h0: lit = "abcdef";
			4'h1: lit = "bc";
			4'h2: lit = "abdeg";
			4'h3: lit = "abcdg";
			4'h4: lit = "bcfg";
			4'h5: lit = "acdfg";
			4'h6: lit = "acdefg";
			4'h7: lit = "abc";
			4'h8: lit = "abcdefg";
			4'h9: lit = "abcdfg";
			4'ha: lit = "abcefg";
			4'hb: lit = "cdefg";
			4'hc: lit = "adef";
			4'hd: lit = "bcdeg";
			4'he: lit = "adefg";
			default: lit = "aefg";
		endcase
		pat = '1;
		for (int i = 0; i < lit.len(); i++)
			pat[lit[i] - "a"] = 1'b0;
		return pat;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic begin_test();
		test_start_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed", name);
			tests_failed++;
		end
	endtask

	task automatic fill_flash();
		for (int i = 0; i < BOOT_WORDS; i++)
			flash_mem[i] = $random(seed);
	endtask

	task automatic clear_sram();
		for (int i = 0; i < BOOT_WORDS; i++)
			sram_mem[i] = '0;
		write_cnt = 0;
		stray_writes = 0;
		unselected_writes = 0;
	endtask

	// Pulses start, notes whether boot_done cleared, then counts cycles until it is high
	task automatic run_copy();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		run_cycles = 1;
		@(negedge clk);
		done_fell = !boot_done;
		while (!boot_done) begin
			@(posedge clk);
			run_cycles++;
			@(negedge clk);
		end
	endtask

	task automatic check_copy(input string name);
		check_value({name, " writes"}, BOOT_WORDS, write_cnt);
		check_value({name, " stray writes"}, 0, stray_writes);
		check_value({name, " writes without enable"}, 0, unselected_writes);
		for (int i = 0; i < BOOT_WORDS; i++)
			check_value($sformatf("%s word %0d", name, i), flash_mem[i], sram_mem[i]);
	endtask

	initial begin
		arst_n = 1'b0;
		start = 1'b0;
		fill_flash();
		clear_sram();
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);

		begin_test();
		check_value("idle flash_ce_n", 1'b1, flash_ce_n);
		check_value("idle flash_oe_n", 1'b1, flash_oe_n);
		check_value("idle ram_en_n", 1'b1, ram_en_n);
		check_value("idle ram_we_n", 1'b1, ram_we_n);
		check_value("idle boot_done", 1'b0, boot_done);
		check_value("idle checksum", 16'h0000, checksum);
		check_value("idle seg_hi", ref_seg(4'h0), seg_hi);
		check_value("idle seg_lo", ref_seg(4'h0), seg_lo);
		end_test("reset_idle");

		run_copy();

		begin_test();
		check_copy("copy");
		end_test("copy_contents");

		begin_test();
		check_value("done checksum", ref_checksum(), checksum);
		check_value("done cycles", 1 + BOOT_WORDS * WORD_CYCLES, run_cycles);
		repeat (20) @(negedge clk);
		check_value("done held", 1'b1, boot_done);
		end_test("checksum_done");

		begin_test();
		check_value("strobe overlap cycles", 0, overlap_cnt);
		end_test("no_overlap");

		begin_test();
		check_value("done seg_hi", ref_seg(4'((BOOT_WORDS >> 4) & 15)), seg_hi);
		check_value("done seg_lo", ref_seg(4'(BOOT_WORDS & 15)), seg_lo);
		end_test("display");

		begin_test();
		fill_flash();
		clear_sram();
		run_copy();
		check_value("rerun done fell", 1'b1, done_fell);
		check_value("rerun cycles", 1 + BOOT_WORDS * WORD_CYCLES, run_cycles);
		check_copy("rerun");
		check_value("rerun checksum", ref_checksum(), checksum);
		check_value("rerun strobe overlap cycles", 0, overlap_cnt);
		end_test("rerun");

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== list.f ====
source/boot_pkg.sv
source/mem_req_if.sv
source/flash_reader.sv
source/boot_sequencer.sv
source/ram_writer.sv
source/seg_decoder.sv
source/boot_top.sv
bench/boot_top_tb.sv

// ==== source/boot_pkg.sv ====
package boot_pkg;

	localparam int WORD_W = 16;
	localparam int FLASH_AW = 22;
	localparam int RAM_AW = 18;
	localparam int SEG_W = 7;

	// One data word, same width on flash and SRAM
	typedef logic [WORD_W-1:0] word_t;

	// Flash word address, byte address bit 0 dropped
	typedef logic [FLASH_AW-1:0] flash_addr_t;

	// SRAM word address
	typedef logic [RAM_AW-1:0] ram_addr_t;

	// Active low, segment a in bit 0
	typedef logic [SEG_W-1:0] seg_t;

endpackage

// ==== source/boot_sequencer.sv ====
`timescale 1ns/10ps

module boot_sequencer import boot_pkg::*; #(
	parameter int BOOT_WORDS = 256
) (
	input logic clk,
	input logic arst_n,
	input logic start,
	mem_req_if.master flash_bus,
	mem_req_if.master ram_bus,
	output logic [15:0] count,
	output word_t checksum,
	output logic boot_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE,
		ST_DONE
	} state_t;

	state_t state;
	logic flash_req;
	logic ram_req;
	logic last_word;
	word_t word_q;

	assign last_word = (count == 16'(BOOT_WORDS - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			flash_req <= 1'b0;
			ram_req <= 1'b0;
			count <= '0;
			checksum <= '0;
			boot_done <= 1'b0;
		end else begin
			flash_req <= 1'b0;
			ram_req <= 1'b0;
			case (state)
				// Start ignored while a copy runs
				ST_IDLE, ST_DONE: begin
					if (start) begin
						state <= ST_READ;
						flash_req <= 1'b1;
						count <= '0;
						checksum <= '0;
						boot_done <= 1'b0;
					end
				end
				ST_READ: begin
					if (flash_bus.done) begin
						state <= ST_WRITE;
						ram_req <= 1'b1;
						checksum <= checksum + flash_bus.data;
					end
				end
				ST_WRITE: begin
					if (ram_bus.done) begin
						count <= count + 1'b1;
						if (last_word) begin
							state <= ST_DONE;
							boot_done <= 1'b1;
						end else begin
							state <= ST_READ;
							flash_req <= 1'b1;
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Word passed from the flash read to the SRAM write
	always_ff @(posedge clk) begin
		if (state == ST_READ && flash_bus.done)
			word_q <= flash_bus.data;
	end

	// Same index on both sides
	assign flash_bus.req = flash_req;
	assign flash_bus.addr = flash_addr_t'(count);

	assign ram_bus.req = ram_req;
	assign ram_bus.addr = flash_addr_t'(count);
	assign ram_bus.data = word_q;

	a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
		count <= 16'(BOOT_WORDS));

	// Only one memory access in flight
	a_flash_alone: assert property (@(posedge clk) disable iff (!arst_n)
		flash_bus.req |-> (!ram_bus.req && !ram_bus.done) until_with flash_bus.done);

	a_ram_alone: assert property (@(posedge clk) disable iff (!arst_n)
		ram_bus.req |-> (!flash_bus.req && !flash_bus.done) until_with ram_bus.done);

endmodule

// ==== source/boot_top.sv ====
`timescale 1ns/10ps

module boot_top import boot_pkg::*; #(
	parameter int BOOT_WORDS = 256,
	parameter int FLASH_WAIT = 4,
	parameter int RAM_WAIT = 2
) (
	input logic raw_clk,
	input logic arst_n,
	input logic start,
	output flash_addr_t flash_addr,
	output logic flash_ce_n,
	output logic flash_oe_n,
	input word_t flash_data,
	output ram_addr_t ram_addr,
	output word_t ram_data,
	output logic ram_en_n,
	output logic ram_we_n,
	output seg_t seg_hi,
	output seg_t seg_lo,
	output word_t checksum,
	output logic boot_done
);

	logic [15:0] count;

	mem_req_if flash_bus();
	mem_req_if ram_bus();

	boot_sequencer #(
		.BOOT_WORDS(BOOT_WORDS)
	) __boot_sequencer (
		.clk(raw_clk),
		.arst_n(arst_n),
		.start(start),
		.flash_bus(flash_bus.master),
		.ram_bus(ram_bus.master),
		.count(count),
		.checksum(checksum),
		.boot_done(boot_done)
	);

	flash_reader #(
		.FLASH_WAIT(FLASH_WAIT)
	) __flash_reader (
		.clk(raw_clk),
		.arst_n(arst_n),
		.bus(flash_bus.slave),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n)
	);

	ram_writer #(
		.RAM_WAIT(RAM_WAIT)
	) __ram_writer (
		.clk(raw_clk),
		.arst_n(arst_n),
		.bus(ram_bus.slave),
		.ram_addr(ram_addr),
		.ram_data(ram_data),
		.ram_en_n(ram_en_n),
		.ram_we_n(ram_we_n)
	);

	// Low byte of the copy count
	seg_decoder __seg_hi (
		.nibble(count[7:4]),
		.seg(seg_hi)
	);

	seg_decoder __seg_lo (
		.nibble(count[3:0]),
		.seg(seg_lo)
	);

endmodule

// ==== source/flash_reader.sv ====
`timescale 1ns/10ps

module flash_reader import boot_pkg::*; #(
	parameter int FLASH_WAIT = 4
) (
	input logic clk,
	input logic arst_n,
	mem_req_if.slave bus,
	output flash_addr_t flash_addr,
	input word_t flash_data,
	output logic flash_ce_n,
	output logic flash_oe_n
);

	localparam int CNT_W = (FLASH_WAIT > 1) ? $clog2(FLASH_WAIT) : 1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_DONE
	} state_t;

	state_t state;
	logic [CNT_W-1:0] wait_cnt;
	logic last_cycle;
	word_t data_q;

	assign last_cycle = (state == ST_ACCESS) && (wait_cnt == CNT_W'(FLASH_WAIT - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					wait_cnt <= '0;
					if (bus.req)
						state <= ST_ACCESS;
				end
				ST_ACCESS: begin
					if (last_cycle)
						state <= ST_DONE;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Address held for the whole access, word taken on the last strobe cycle
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && bus.req)
			flash_addr <= bus.addr;
		if (last_cycle)
			data_q <= flash_data;
	end

	assign flash_ce_n = (state != ST_ACCESS);
	assign flash_oe_n = (state != ST_ACCESS);

	assign bus.done = (state == ST_DONE);
	assign bus.data = data_q;

	// Sequencer must wait for done before the next read
	a_req_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		bus.req |-> state == ST_IDLE);

endmodule

// ==== source/mem_req_if.sv ====
`timescale 1ns/10ps

interface mem_req_if import boot_pkg::*; ();

	logic req;
	flash_addr_t addr;
	// Driven by the reader on the flash side, by the sequencer on the SRAM side
	wire word_t data;
	logic done;

	modport master (
		output req,
		output addr,
		inout data,
		input done
	);

	modport slave (
		input req,
		input addr,
		inout data,
		output done
	);

endinterface

// ==== source/ram_writer.sv ====
`timescale 1ns/10ps

module ram_writer import boot_pkg::*; #(
	parameter int RAM_WAIT = 2
) (
	input logic clk,
	input logic arst_n,
	mem_req_if.slave bus,
	output ram_addr_t ram_addr,
	output word_t ram_data,
	output logic ram_en_n,
	output logic ram_we_n
);

	localparam int CNT_W = (RAM_WAIT > 1) ? $clog2(RAM_WAIT) : 1;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_DONE
	} state_t;

	state_t state;
	logic [CNT_W-1:0] wait_cnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					wait_cnt <= '0;
					if (bus.req)
						state <= ST_WRITE;
				end
				ST_WRITE: begin
					if (wait_cnt == CNT_W'(RAM_WAIT - 1))
						state <= ST_DONE;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// SRAM takes only the low address bits
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && bus.req) begin
			ram_addr <= bus.addr[RAM_AW-1:0];
			ram_data <= bus.data;
		end
	end

	assign ram_en_n = (state != ST_WRITE);
	assign ram_we_n = (state != ST_WRITE);

	assign bus.done = (state == ST_DONE);

	// Address and data must not move under the write strobe
	a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
		!ram_we_n |=> ram_we_n || ($stable(ram_addr) && $stable(ram_data)));

endmodule

// ==== source/seg_decoder.sv ====
`timescale 1ns/10ps

module seg_decoder import boot_pkg::*; (
	input logic [3:0] nibble,
	output seg_t seg
);

	// Patterns written active high as gfedcba, then inverted
	always_comb begin
		case (nibble)
			4'h0: seg = ~7'h3f;
			4'h1: seg = ~7'h06;
			4'h2: seg = ~7'h5b;
			4'h3: seg = ~7'h4f;
			4'h4: seg = ~7'h66;
			4'h5: seg = ~7'h6d;
			4'h6: seg = ~7'h7d;
			4'h7: seg = ~7'h07;
			4'h8: seg = ~7'h7f;
			4'h9: seg = ~7'h6f;
			4'ha: seg = ~7'h77;
			4'hb: seg = ~7'h7c;
			4'hc: seg = ~7'h39;
			4'hd: seg = ~7'h5e;
			4'he: seg = ~7'h79;
			default: seg = ~7'h71;
		endcase
	end

endmodule
